/* design/clauseTree_config.svh */
/*
 * build-time sizing for the clause collection tree
 * included by the packages and by any module that needs a width or a depth
 */
`ifndef CLAUSE_TREE_CONFIG_SVH
`define CLAUSE_TREE_CONFIG_SVH

// clause slots offered in one batch, must divide evenly over four lanes
`define CLAUSE_COUNT 20

// bits in one learned clause word
`define CLAUSE_WIDTH 36

// entries per buffer
// small on purpose so a stalled consumer reaches overflow quickly
`define BUFFER_DEPTH 4

`endif

/* design/clausePkg.sv */
/*
 * clause data types and lane geometry shared by every stage of the tree
 * imported wherever a clause word, a batch or a slot index is handled
 */
`include "clauseTree_config.svh"

package clausePkg;

    // one learned clause
    typedef logic [`CLAUSE_WIDTH-1:0] clause_t;

    // whole batch, slot 0 in the low bits
    typedef clause_t [`CLAUSE_COUNT-1:0] clauseBatch_t;

    // first-level lane buffers
    localparam int LANE_COUNT = 4;

    // lane k owns slots k*SLOTS_PER_LANE up to k*SLOTS_PER_LANE + SLOTS_PER_LANE - 1
    localparam int SLOTS_PER_LANE = `CLAUSE_COUNT / LANE_COUNT;

    // slot counter of the intake scan
    typedef logic [2:0] slotIdx_t;

endpackage

/* design/treeCtrlPkg.sv */
/*
 * control encodings for the intake sequencer and the merge stages
 */
package treeCtrlPkg;

    // intake sequencer
    // IDLE waits for a batch, SCAN walks slots 1 to 4 of every lane
    typedef enum logic
    {
        IDLE,
        SCAN
    } intakeState_t;

    // upstream buffer a merge stage currently favours
    typedef enum logic
    {
        SEL_A,
        SEL_B
    } mergeSel_t;

endpackage

/* design/fifoLink.sv */
/*
 * one buffer's write side and read side as seen between two stages
 * producer binds writer, buffer binds fifo, consumer binds reader
 */
`timescale 1ns/1ps

interface fifoLink;
    import clausePkg::*;

    // write side
    clause_t wdata;
    logic    wren;
    logic    full;

    // read side, rdata is the head word whenever empty is low
    clause_t rdata;
    logic    empty;
    logic    rden;

    modport writer (output wdata, output wren, input full);

    modport reader (input rdata, input empty, output rden);

    modport fifo (input wdata, input wren, input rden, output full, output rdata, output empty);

endinterface

/* design/clauseFifo.sv */
/*
 * first-word-fall-through clause buffer used at every level of the tree
 * head word is always on rdata, a write while full is simply not stored
 */
`timescale 1ns/1ps
`include "clauseTree_config.svh"

module clauseFifo (
    input logic   clk,
    input logic   reset,
    fifoLink.fifo link
);
    import clausePkg::*;

    localparam int DEPTH = `BUFFER_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    clause_t            mem [DEPTH];
    logic [PTR_W-1:0]   rdPtr;
    logic [PTR_W-1:0]   wrPtr;
    logic [CNT_W-1:0]   count;
    logic               doWrite;
    logic               doRead;

    // full blocks the write even when a read frees a slot this cycle
    assign doWrite = link.wren & ~link.full;
    assign doRead  = link.rden & ~link.empty;

    assign link.full  = (count == CNT_W'(DEPTH));
    assign link.empty = (count == '0);
    assign link.rdata = mem[rdPtr];

    // storage
    always_ff @(posedge clk)
    begin
        if (doWrite)
            mem[wrPtr] <= link.wdata;
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doWrite)
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doRead)
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (doWrite && !doRead)
                count <= count + 1'b1;
            else if (doRead && !doWrite)
                count <= count - 1'b1;
        end
    end

    // consumers must only pop a non-empty buffer
    assert property (@(posedge clk) disable iff (reset) link.rden |-> !link.empty)
        else $error("pop of empty clause buffer");

endmodule

/* design/clauseIntake.sv */
/*
 * decode stage: spreads one accepted batch over the four lane buffers
 * slot 0 of every lane goes in on the strobe cycle, slots 1 to 4 follow
 * one per cycle; the batch must stay on clauses_i for the whole scan
 */
`timescale 1ns/1ps
`include "clauseTree_config.svh"

module clauseIntake (
    input  logic                    clk,
    input  logic                    reset,
    input  clausePkg::clauseBatch_t clauses_i,
    input  logic [`CLAUSE_COUNT-1:0] clauseValid_i,
    input  logic                    wren_i,
    fifoLink.writer                 lane0_o,
    fifoLink.writer                 lane1_o,
    fifoLink.writer                 lane2_o,
    fifoLink.writer                 lane3_o,
    output logic                    overflowEvent_o
);
    import clausePkg::*;
    import treeCtrlPkg::*;

    intakeState_t          state;
    slotIdx_t              slotCnt;
    slotIdx_t              curSlot;
    logic                  scanActive;
    logic [LANE_COUNT-1:0] laneWr;
    logic [LANE_COUNT-1:0] laneFull;
    clause_t               laneData [LANE_COUNT];

    // strobe cycle always takes slot 0, a strobe mid-scan restarts the walk
    assign curSlot    = wren_i ? '0 : slotCnt;
    assign scanActive = wren_i | (state == SCAN);

    // same slot of every lane in parallel
    always_comb
    begin
        int idx;
        for (int k = 0; k < LANE_COUNT; k++)
        begin
            idx         = k * SLOTS_PER_LANE + int'(curSlot);
            laneWr[k]   = scanActive & clauseValid_i[idx];
            laneData[k] = clauses_i[idx];
        end
    end

    assign lane0_o.wren  = laneWr[0];
    assign lane1_o.wren  = laneWr[1];
    assign lane2_o.wren  = laneWr[2];
    assign lane3_o.wren  = laneWr[3];
    assign lane0_o.wdata = laneData[0];
    assign lane1_o.wdata = laneData[1];
    assign lane2_o.wdata = laneData[2];
    assign lane3_o.wdata = laneData[3];

    assign laneFull = {lane3_o.full, lane2_o.full, lane1_o.full, lane0_o.full};

    // a valid slot landing on a full lane is lost
    assign overflowEvent_o = |(laneWr & laneFull);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= IDLE;
            slotCnt <= '0;
        end
        else if (wren_i)
        begin
            state   <= SCAN;
            slotCnt <= slotIdx_t'(1);
        end
        else if (state == SCAN)
        begin
            // last slot written this cycle
            if (slotCnt == slotIdx_t'(SLOTS_PER_LANE - 1))
            begin
                state   <= IDLE;
                slotCnt <= '0;
            end
            else
                slotCnt <= slotCnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        slotCnt <= slotIdx_t'(SLOTS_PER_LANE - 1))
        else $error("intake slot counter past last lane slot");

endmodule

/* design/mergeStage.sv */
/*
 * execute stage: two-to-one merge between two upstream buffers
 * the select alternates toward whichever side has data so neither starves
 * a word popped at one edge is written downstream at the next edge
 */
`timescale 1ns/1ps

module mergeStage (
    input  logic    clk,
    input  logic    reset,
    fifoLink.reader srcA_i,
    fifoLink.reader srcB_i,
    fifoLink.writer dst_o,
    output logic    overflowEvent_o
);
    import clausePkg::*;
    import treeCtrlPkg::*;

    mergeSel_t sel;
    logic      popA;
    logic      popB;
    logic      wrReg;
    clause_t   dataReg;

    // favoured side first, the other side only when the favoured one is dry
    assign popA = ~srcA_i.empty & ((sel == SEL_A) | srcB_i.empty);
    assign popB = ~srcB_i.empty & ((sel == SEL_B) | srcA_i.empty);

    assign srcA_i.rden = popA;
    assign srcB_i.rden = popB;

    // registered write into own buffer
    assign dst_o.wren  = wrReg;
    assign dst_o.wdata = dataReg;

    // dropped registered write
    assign overflowEvent_o = wrReg & dst_o.full;

    // control path
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sel   <= SEL_A;
            wrReg <= 1'b0;
        end
        else
        begin
            wrReg <= popA | popB;
            // swap sides only when the other side has something waiting
            if (sel == SEL_A && !srcB_i.empty)
                sel <= SEL_B;
            else if (sel == SEL_B && !srcA_i.empty)
                sel <= SEL_A;
        end
    end

    // payload, only meaningful while wrReg is high
    always_ff @(posedge clk)
    begin
        dataReg <= popA ? srcA_i.rdata : srcB_i.rdata;
    end

    // one pop per cycle at most, each upstream buffer sees its own rden
    assert property (@(posedge clk) disable iff (reset) !(srcA_i.rden && srcB_i.rden))
        else $error("merge stage popped both sources");

endmodule

/* design/resultStage.sv */
/*
 * result stage: holds the output buffer the consumer reads from
 * and collects every dropped write in the tree into a sticky overflow flag
 */
`timescale 1ns/1ps

module resultStage (
    input  logic              clk,
    input  logic              reset,
    fifoLink                  in_i,
    input  logic              rden_i,
    input  logic              clearOverflow_i,
    input  logic [3:0]        overflowEvents_i,
    output clausePkg::clause_t clause_o,
    output logic              empty_o,
    output logic              overflow_o
);
    logic ownDrop;
    logic anyDrop;

    // output buffer, written by the last merge stage
    clauseFifo u_outFifo (
        .clk   (clk),
        .reset (reset),
        .link  (in_i)
    );

    // consumer strobe never reaches an empty buffer
    assign in_i.rden = rden_i & ~in_i.empty;

    // head word shows through with no register
    assign clause_o = in_i.rdata;
    assign empty_o  = in_i.empty;

    assign ownDrop = in_i.wren & in_i.full;
    assign anyDrop = ownDrop | (|overflowEvents_i);

    // sticky, a drop in the clear cycle keeps it set
    always_ff @(posedge clk)
    begin
        if (reset)
            overflow_o <= 1'b0;
        else
            overflow_o <= (overflow_o & ~clearOverflow_i) | anyDrop;
    end

endmodule

/* design/clauseTree.sv */
/*
 * clause collection tree top level
 * intake -> four lane buffers -> two merges -> two buffers -> final merge -> output buffer
 */
`timescale 1ns/1ps
`include "clauseTree_config.svh"

module clauseTree (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [`CLAUSE_COUNT*`CLAUSE_WIDTH-1:0] clauses_i,
    input  logic [`CLAUSE_COUNT-1:0]              clauseValid_i,
    input  logic                                  wren_i,
    input  logic                                  rden_i,
    input  logic                                  clearOverflow_i,
    output logic [`CLAUSE_WIDTH-1:0]              clause_o,
    output logic                                  empty_o,
    output logic                                  overflow_o
);
    // lanes 0 to 3, then level-one buffers, then the output buffer
    fifoLink laneLink [4] ();
    fifoLink l1aLink ();
    fifoLink l1bLink ();
    fifoLink resultLink ();

    logic intakeEvent;
    logic l1aEvent;
    logic l1bEvent;
    logic l2Event;

    clauseIntake u_intake (
        .clk (clk), .reset (reset), .clauses_i (clauses_i),
        .clauseValid_i (clauseValid_i), .wren_i (wren_i),
        .lane0_o (laneLink[0]), .lane1_o (laneLink[1]),
        .lane2_o (laneLink[2]), .lane3_o (laneLink[3]),
        .overflowEvent_o (intakeEvent)
    );

    for (genvar i = 0; i < 4; i++)
    begin : g_lane
        clauseFifo u_laneFifo (.clk (clk), .reset (reset), .link (laneLink[i]));
    end

    clauseFifo u_l1aFifo (.clk (clk), .reset (reset), .link (l1aLink));
    clauseFifo u_l1bFifo (.clk (clk), .reset (reset), .link (l1bLink));

    // level one, lanes 0/1 and 2/3
    mergeStage u_mergeL1a (
        .clk (clk), .reset (reset), .srcA_i (laneLink[0]), .srcB_i (laneLink[1]),
        .dst_o (l1aLink), .overflowEvent_o (l1aEvent)
    );
    mergeStage u_mergeL1b (
        .clk (clk), .reset (reset), .srcA_i (laneLink[2]), .srcB_i (laneLink[3]),
        .dst_o (l1bLink), .overflowEvent_o (l1bEvent)
    );

    // level two feeds the output buffer
    mergeStage u_mergeL2 (
        .clk (clk), .reset (reset), .srcA_i (l1aLink), .srcB_i (l1bLink),
        .dst_o (resultLink), .overflowEvent_o (l2Event)
    );

    resultStage u_result (
        .clk (clk), .reset (reset), .in_i (resultLink), .rden_i (rden_i),
        .clearOverflow_i (clearOverflow_i),
        .overflowEvents_i ({l2Event, l1bEvent, l1aEvent, intakeEvent}),
        .clause_o (clause_o), .empty_o (empty_o), .overflow_o (overflow_o)
    );

endmodule

/* testbench/clauseTreeTb.sv */
/*
 * self-checking testbench for the clause collection tree
 * drives tagged random batches, pops the output and checks it against a clause scoreboard
 * port-level behavior is checked by concurrent assertions
 */
`timescale 1ns/1ps
`include "clauseTree_config.svh"

module clauseTreeTb;
    import clausePkg::*;

    logic                                   clk;
    logic                                   reset;
    logic [`CLAUSE_COUNT*`CLAUSE_WIDTH-1:0] clauses_i;
    logic [`CLAUSE_COUNT-1:0]               clauseValid_i;
    logic                                   wren_i;
    logic                                   rden_i;
    logic                                   clearOverflow_i;
    logic [`CLAUSE_WIDTH-1:0]               clause_o;
    logic                                   empty_o;
    logic                                   overflow_o;

    // phase flags for the port assertions
    logic lowLoad;
    logic expectEmpty;
    logic expectOverflow;

    int   valueErrors;
    int   otherErrors;
    int   batchNum;
    bit   pendingHit;
    clause_t poppedWord;

    // clauses that must come out, and clauses from overflow batches that may
    int reqCount [bit [`CLAUSE_WIDTH-1:0]];
    int optCount [bit [`CLAUSE_WIDTH-1:0]];

    clauseTree u_clauseTree (
        .clk (clk), .reset (reset), .clauses_i (clauses_i), .clauseValid_i (clauseValid_i),
        .wren_i (wren_i), .rden_i (rden_i), .clearOverflow_i (clearOverflow_i),
        .clause_o (clause_o), .empty_o (empty_o), .overflow_o (overflow_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one wrong single-bit port value
    task automatic reportMismatch(input string name, input logic got, input logic expected);
        valueErrors++;
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, expected);
    endtask

    // reset values
    assert property (@(posedge clk) $fell(reset) |-> empty_o)
        else reportMismatch("empty_o", $sampled(empty_o), 1'b1);
    assert property (@(posedge clk) $fell(reset) |-> !overflow_o)
        else reportMismatch("overflow_o", $sampled(overflow_o), 1'b0);

    // at most BUFFER_DEPTH words in flight, nothing can be full
    assert property (@(posedge clk) disable iff (reset) lowLoad |-> !overflow_o)
        else reportMismatch("overflow_o", $sampled(overflow_o), 1'b0);

    // batch with no valid slots
    assert property (@(posedge clk) disable iff (reset) expectEmpty |-> empty_o)
        else reportMismatch("empty_o", $sampled(empty_o), 1'b1);

    // sticky until cleared
    assert property (@(posedge clk) disable iff (reset) expectOverflow |-> overflow_o)
        else reportMismatch("overflow_o", $sampled(overflow_o), 1'b1);
    assert property (@(posedge clk) disable iff (reset) overflow_o && !clearOverflow_i |=> overflow_o)
        else reportMismatch("overflow_o", $sampled(overflow_o), 1'b1);

    // clear on a quiet tree
    assert property (@(posedge clk) disable iff (reset) clearOverflow_i && empty_o |=> !overflow_o)
        else reportMismatch("overflow_o", $sampled(overflow_o), 1'b0);

    // scoreboard, every popped word must be pending exactly once
    always @(posedge clk)
    begin
        if (!reset && rden_i && !empty_o)
        begin
            poppedWord = clause_o;
            pendingHit = 1'b1;
            if (reqCount.exists(poppedWord) && reqCount[poppedWord] > 0)
                reqCount[poppedWord] = reqCount[poppedWord] - 1;
            else if (optCount.exists(poppedWord) && optCount[poppedWord] > 0)
                optCount[poppedWord] = optCount[poppedWord] - 1;
            else
                pendingHit = 1'b0;
            assert (pendingHit)
            else
            begin
                valueErrors++;
                $display("[FAIL] %0t clause_o got %h expected a pending clause", $time, poppedWord);
            end
        end
    end

    // tag = batch and slot, low byte random
    function automatic clause_t makeClause(input int batch, input int slot);
        logic [31:0] r;
        r = $urandom();
        return {4'hC, batch[15:0], slot[7:0], r[7:0]};
    endfunction

    // keep at most perLane valid slots per lane and total overall
    function automatic logic [`CLAUSE_COUNT-1:0] thinMask(input logic [`CLAUSE_COUNT-1:0] raw,
                                                         input int perLane, input int total);
        logic [`CLAUSE_COUNT-1:0] kept;
        int laneUsed;
        int used;
        kept = '0;
        used = 0;
        for (int k = 0; k < LANE_COUNT; k++)
        begin
            laneUsed = 0;
            for (int s = 0; s < SLOTS_PER_LANE; s++)
            begin
                if (raw[k*SLOTS_PER_LANE+s] && laneUsed < perLane && used < total)
                begin
                    kept[k*SLOTS_PER_LANE+s] = 1'b1;
                    laneUsed++;
                    used++;
                end
            end
        end
        return kept;
    endfunction

    function automatic logic [`CLAUSE_COUNT-1:0] randomMask();
        logic [31:0] r;
        r = $urandom();
        return r[`CLAUSE_COUNT-1:0];
    endfunction

    // called on a falling edge, intake scan takes five cycles
    task automatic sendBatch(input logic [`CLAUSE_COUNT-1:0] mask, input bit required);
        clause_t word;
        for (int s = 0; s < `CLAUSE_COUNT; s++)
        begin
            word = makeClause(batchNum, s);
            clauses_i[s*`CLAUSE_WIDTH +: `CLAUSE_WIDTH] = word;
            if (mask[s] && required)
                reqCount[word] = reqCount.exists(word) ? reqCount[word] + 1 : 1;
            else if (mask[s])
                optCount[word] = optCount.exists(word) ? optCount[word] + 1 : 1;
        end
        clauseValid_i = mask;
        wren_i = 1'b1;
        @(negedge clk);
        wren_i = 1'b0;
        // batch held until the scan is done
        repeat (SLOTS_PER_LANE - 1) @(negedge clk);
        batchNum++;
    endtask

    // pop until empty_o has stayed high long enough for the tree to be dry
    task automatic drainTree(input int maxCycles);
        int quiet;
        int cycles;
        quiet = 0;
        cycles = 0;
        rden_i = 1'b1;
        while (quiet < 12 && cycles < maxCycles)
        begin
            @(negedge clk);
            cycles++;
            quiet = empty_o ? quiet + 1 : 0;
        end
        if (quiet < 12)
        begin
            otherErrors++;
            $display("timeout: output buffer still delivering clauses at %0t", $time);
        end
    endtask

    task automatic waitOverflow(input int maxCycles);
        int cycles;
        cycles = 0;
        while (!overflow_o && cycles < maxCycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!overflow_o)
        begin
            otherErrors++;
            $display("timeout: overflow flag never rose with the consumer stalled");
        end
    endtask

    initial
    begin
        void'($urandom(67));
        reset = 1'b1;
        clauses_i = '0;
        clauseValid_i = '0;
        wren_i = 1'b0;
        rden_i = 1'b0;
        clearOverflow_i = 1'b0;
        lowLoad = 1'b0;
        expectEmpty = 1'b0;
        expectOverflow = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        batchNum = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // light batches, drained each time
        lowLoad = 1'b1;
        rden_i = 1'b1;
        repeat (3)
        begin
            sendBatch(thinMask(randomMask(), SLOTS_PER_LANE, `BUFFER_DEPTH), 1'b1);
            drainTree(200);
        end
        lowLoad = 1'b0;

        // nothing valid, nothing out
        expectEmpty = 1'b1;
        sendBatch('0, 1'b1);
        repeat (10) @(negedge clk);
        expectEmpty = 1'b0;

        // half a buffer per lane keeps each level-one branch within BUFFER_DEPTH
        repeat (6)
        begin
            sendBatch(thinMask(randomMask(), `BUFFER_DEPTH / 2, `CLAUSE_COUNT), 1'b1);
            drainTree(200);
        end

        // stalled consumer, 40 words against a capacity of 28
        rden_i = 1'b0;
        sendBatch('1, 1'b0);
        sendBatch('1, 1'b0);
        waitOverflow(50);
        expectOverflow = 1'b1;
        drainTree(300);
        expectOverflow = 1'b0;

        clearOverflow_i = 1'b1;
        @(negedge clk);
        clearOverflow_i = 1'b0;
        @(negedge clk);

        // flag stays low again under light load
        lowLoad = 1'b1;
        sendBatch(thinMask(randomMask(), SLOTS_PER_LANE, `BUFFER_DEPTH), 1'b1);
        drainTree(200);
        lowLoad = 1'b0;

        foreach (reqCount[w])
        begin
            if (reqCount[w] != 0)
            begin
                otherErrors++;
                $display("clause %h was written but never read out", w);
            end
        end

        $display("checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/clausePkg.sv
design/treeCtrlPkg.sv
design/fifoLink.sv
design/clauseFifo.sv
design/clauseIntake.sv
design/mergeStage.sv
design/resultStage.sv
design/clauseTree.sv
testbench/clauseTreeTb.sv

/* run.sh */
#!/bin/sh
# compiles the clause tree testbench with Verilator and runs it
# exits non-zero unless the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module clauseTreeTb -o clauseTreeSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/clauseTreeSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
